/* tb.f */
+incdir+testbench
source/mips_pkg.sv
source/fetch_unit.sv
source/register_file.sv
source/decode_stage.sv
source/execute_stage.sv
source/hazard_control.sv
source/mips_core.sv
testbench/tb_mips_core.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_mips_core
FILELIST  ?= tb.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "STATUS: FAIL" $(LOG); then \
		echo "simulation reported failure"; exit 1; \
	fi
	@if ! grep -q "STATUS: PASS" $(LOG); then \
		echo "simulation ended without a result"; exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* testbench/tb_program.svh */
`ifndef TB_PROGRAM_SVH
`define TB_PROGRAM_SVH

int unsigned          lcg_state = 52303;  // random stream seed
mips_pkg::word_t      model_regs [mips_pkg::NUM_REGS];
mips_pkg::exc_cause_t model_cause;
mips_pkg::word_t      model_epc;

function automatic mips_pkg::word_t encode_rtype(logic [5:0] fn, int rd, int rs, int rt);
    return {mips_pkg::OPC_RTYPE, mips_pkg::reg_addr_t'(rs), mips_pkg::reg_addr_t'(rt),
            mips_pkg::reg_addr_t'(rd), 5'd0, fn};
endfunction

function automatic mips_pkg::word_t encode_itype(logic [5:0] op, int rt, int rs, logic [15:0] imm);
    return {op, mips_pkg::reg_addr_t'(rs), mips_pkg::reg_addr_t'(rt), imm};
endfunction

// beq r0, r0, -1 branches onto itself
function automatic mips_pkg::word_t loop_word();
    return encode_itype(mips_pkg::OPC_BEQ, 0, 0, 16'hFFFF);
endfunction

function automatic logic [15:0] next_random();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state[30:15];  // upper bits are the better ones
endfunction

// in-order execution of the loaded program, stops at the first exception
task automatic run_reference();
    mips_pkg::word_t     pc;
    mips_pkg::word_t     next_pc;
    mips_pkg::word_t     offset;
    mips_pkg::word_t     ins;
    mips_pkg::word_t     a;
    mips_pkg::word_t     b;
    mips_pkg::word_t     imm;
    mips_pkg::word_t     res;
    logic [32:0]         wide;
    mips_pkg::reg_addr_t dest;
    logic                writes;
    logic                illegal;
    logic                ovf;
    int                  steps;
    for (int i = 0; i < mips_pkg::NUM_REGS; i++)
        model_regs[i] = '0;
    model_cause = mips_pkg::EXC_NONE;
    model_epc   = '0;
    pc          = mips_pkg::RESET_PC;
    offset      = '0;
    steps       = 0;
    while (offset < 32'(4 * program_len) && steps < 1000 && model_cause == mips_pkg::EXC_NONE)
    begin
        ins     = program_mem[offset[7:2]];
        a       = model_regs[ins[25:21]];
        b       = model_regs[ins[20:16]];
        imm     = {{16{ins[15]}}, ins[15:0]};
        res     = '0;
        wide    = '0;
        dest    = ins[15:11];
        writes  = 1'b0;
        illegal = 1'b0;
        ovf     = 1'b0;
        next_pc = pc + 32'd4;
        case (ins[31:26])
            mips_pkg::OPC_RTYPE:
            begin
                writes = 1'b1;
                case (ins[5:0])
                    mips_pkg::FN_ADD: wide = {a[31], a} + {b[31], b};
                    mips_pkg::FN_SUB: wide = {a[31], a} - {b[31], b};
                    mips_pkg::FN_AND: res = a & b;
                    mips_pkg::FN_OR:  res = a | b;
                    mips_pkg::FN_SLT: res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                    default:          illegal = 1'b1;
                endcase
                if (ins[5:0] == mips_pkg::FN_ADD || ins[5:0] == mips_pkg::FN_SUB)
                begin
                    res = wide[31:0];
                    ovf = wide[32] ^ wide[31];  // sign lost in 32 bits
                end
            end
            mips_pkg::OPC_ADDI:
            begin
                writes = 1'b1;
                dest   = ins[20:16];
                wide   = {a[31], a} + {imm[31], imm};
                res    = wide[31:0];
                ovf    = wide[32] ^ wide[31];
            end
            mips_pkg::OPC_BEQ:
                if (a == b)
                    next_pc = pc + 32'd4 + (imm << 2);
            mips_pkg::OPC_BNE:
                if (a != b)
                    next_pc = pc + 32'd4 + (imm << 2);
            default: illegal = 1'b1;
        endcase
        if (illegal)
            model_cause = mips_pkg::EXC_ILLEGAL;
        else if (writes && dest == '0)
            model_cause = mips_pkg::EXC_ZERO_WRITE;
        else if (writes && ovf)
            model_cause = mips_pkg::EXC_OVERFLOW;
        else if (writes)
            model_regs[dest] = res;
        if (model_cause != mips_pkg::EXC_NONE)
            model_epc = pc;
        pc     = next_pc;
        offset = pc - mips_pkg::RESET_PC;
        steps++;
    end
endtask

`endif

/* testbench/tb_mips_core.sv */
`timescale 1ns/1ps

module tb_mips_core;

    logic                 SYS_clk;
    logic                 SYS_reset;
    mips_pkg::word_t      imem_addr;
    mips_pkg::word_t      imem_data;
    mips_pkg::reg_addr_t  dbg_addr;
    mips_pkg::word_t      dbg_data;
    logic                 halted;
    mips_pkg::exc_cause_t exc_cause;
    mips_pkg::word_t      epc;

    mips_pkg::word_t program_mem [64];
    int              program_len;
    mips_pkg::word_t mem_offset;
    int              test_errors;
    int              tests_passed;
    int              tests_failed;

    `include "tb_program.svh"

    mips_core uut
    (
        .SYS_clk   (SYS_clk),
        .SYS_reset (SYS_reset),
        .imem_addr (imem_addr),
        .imem_data (imem_data),
        .dbg_addr  (dbg_addr),
        .dbg_data  (dbg_data),
        .halted    (halted),
        .exc_cause (exc_cause),
        .epc       (epc)
    );

    initial
    begin
        SYS_clk = 1'b0;
        forever #10 SYS_clk = ~SYS_clk;  // 20 ns period
    end

    // combinational instruction memory with a self-loop word outside the program
    assign mem_offset = imem_addr - mips_pkg::RESET_PC;

    always_comb
    begin
        if (mem_offset < 32'(4 * program_len))
            imem_data = program_mem[mem_offset[7:2]];
        else
            imem_data = loop_word();
    end

    task automatic append_instr(mips_pkg::word_t w);
        program_mem[program_len] = w;
        program_len++;
    endtask

    task automatic apply_reset();
        @(posedge SYS_clk);
        #1;
        SYS_reset = 1'b1;
        dbg_addr  = '0;
        repeat (3) @(posedge SYS_clk);
        #1;
        SYS_reset = 1'b0;
    endtask

    task automatic check_value(string name, mips_pkg::word_t expected, mips_pkg::word_t actual);
        assert (actual === expected)
        else
        begin
            $display("Mismatch at %0t ns: %s expected %h, got %h", $time, name, expected, actual);
            test_errors++;
        end
    endtask

    task automatic read_register(int idx, output mips_pkg::word_t value);
        @(posedge SYS_clk);
        #1;
        dbg_addr = mips_pkg::reg_addr_t'(idx);
        #2;
        value = dbg_data;
    endtask

    task automatic compare_registers();
        mips_pkg::word_t value;
        for (int i = 0; i < mips_pkg::NUM_REGS; i++)
        begin
            read_register(i, value);
            check_value($sformatf("r%0d", i), model_regs[i], value);
        end
    endtask

    task automatic wait_for_completion(output bit timed_out);
        mips_pkg::word_t end_addr;
        int              cycles;
        end_addr = mips_pkg::RESET_PC + 32'(4 * program_len);  // first self-loop fetch
        cycles   = 0;
        while (!halted && imem_addr != end_addr && cycles < 200)
        begin
            @(posedge SYS_clk);
            #1;
            cycles++;
        end
        timed_out = !halted && imem_addr != end_addr;
    endtask

    task automatic run_program();
        bit timed_out;
        apply_reset();
        wait_for_completion(timed_out);
        if (timed_out)
        begin
            $display("Timeout at %0t ns: core neither halted nor reached the end of the program",
                     $time);
            test_errors++;
        end
        else
        begin
            repeat (4) @(posedge SYS_clk);  // drain the pipeline
            #1;
            run_reference();
            check_value("halted", 32'(model_cause != mips_pkg::EXC_NONE), 32'(halted));
            check_value("exc_cause", 32'(model_cause), 32'(exc_cause));
            check_value("epc", model_epc, epc);
            compare_registers();
        end
    endtask

    task automatic report_test(string name);
        if (test_errors == 0)
        begin
            tests_passed++;
            $display("test %s passed", name);
        end
        else
        begin
            tests_failed++;
            $display("test %s failed with %0d errors", name, test_errors);
        end
        test_errors = 0;
    endtask

    task automatic check_reset_state();
        program_len = 0;
        apply_reset();
        check_value("imem_addr", mips_pkg::RESET_PC, imem_addr);
        check_value("halted", 32'd0, 32'(halted));
        check_value("exc_cause", 32'(mips_pkg::EXC_NONE), 32'(exc_cause));
        check_value("epc", 32'd0, epc);
        run_reference();  // empty program keeps every register at zero
        compare_registers();
        report_test("reset");
    endtask

    task automatic run_alu_chain();
        program_len = 0;
        append_instr(encode_itype(mips_pkg::OPC_ADDI, 1, 0, next_random()));
        append_instr(encode_itype(mips_pkg::OPC_ADDI, 2, 1, next_random()));  // stall then bypass
        append_instr(encode_rtype(mips_pkg::FN_ADD, 3, 1, 2));
        append_instr(encode_rtype(mips_pkg::FN_SUB, 4, 3, 1));
        append_instr(encode_rtype(mips_pkg::FN_AND, 5, 4, 3));
        append_instr(encode_rtype(mips_pkg::FN_OR, 6, 5, 2));
        append_instr(encode_rtype(mips_pkg::FN_SLT, 7, 6, 4));
        append_instr(encode_rtype(mips_pkg::FN_SLT, 8, 4, 6));
        append_instr(encode_itype(mips_pkg::OPC_ADDI, 9, 7, next_random()));
        append_instr(encode_rtype(mips_pkg::FN_ADD, 10, 9, 8));
        append_instr(encode_itype(mips_pkg::OPC_ADDI, 11, 0, next_random()));
        append_instr(encode_itype(mips_pkg::OPC_ADDI, 12, 0, next_random()));
        append_instr(encode_itype(mips_pkg::OPC_ADDI, 13, 11, next_random()));  // bypass only
        append_instr(encode_rtype(mips_pkg::FN_SUB, 14, 12, 13));
        run_program();
        report_test("alu_chain");
    endtask

    task automatic run_branch_mix();
        program_len = 0;
        append_instr(encode_itype(mips_pkg::OPC_ADDI, 1, 0, next_random()));
        append_instr(encode_itype(mips_pkg::OPC_ADDI, 2, 1, 16'd0));
        append_instr(encode_itype(mips_pkg::OPC_BEQ, 2, 1, 16'd1));   // taken
        append_instr(encode_itype(mips_pkg::OPC_ADDI, 3, 0, 16'd99)); // skipped
        append_instr(encode_itype(mips_pkg::OPC_ADDI, 4, 1, 16'd7));
        append_instr(encode_itype(mips_pkg::OPC_BNE, 4, 1, 16'd1));   // taken
        append_instr(encode_itype(mips_pkg::OPC_ADDI, 5, 0, 16'd11)); // skipped
        append_instr(encode_itype(mips_pkg::OPC_BEQ, 4, 1, 16'd1));   // not taken
        append_instr(encode_itype(mips_pkg::OPC_ADDI, 6, 0, 16'd13));
        append_instr(encode_itype(mips_pkg::OPC_BNE, 2, 1, 16'd1));   // not taken
        append_instr(encode_itype(mips_pkg::OPC_ADDI, 7, 4, 16'd1));
        append_instr(encode_rtype(mips_pkg::FN_ADD, 8, 6, 7));
        run_program();
        report_test("branches");
    endtask

    task automatic run_overflow_case();
        mips_pkg::word_t fault_pc;
        mips_pkg::word_t value;
        program_len = 0;
        append_instr(encode_itype(mips_pkg::OPC_ADDI, 3, 0, 16'd77));
        append_instr(encode_itype(mips_pkg::OPC_ADDI, 1, 0, 16'h4000));
        for (int i = 0; i < 16; i++)
            append_instr(encode_rtype(mips_pkg::FN_ADD, 1, 1, 1));  // doubles up to 2^30
        append_instr(encode_itype(mips_pkg::OPC_ADDI, 2, 0, 16'd3));
        fault_pc = mips_pkg::RESET_PC + 32'(4 * program_len);
        append_instr(encode_rtype(mips_pkg::FN_ADD, 3, 1, 1));
        append_instr(encode_itype(mips_pkg::OPC_ADDI, 4, 0, 16'd1));
        append_instr(encode_itype(mips_pkg::OPC_ADDI, 2, 0, 16'd9));
        append_instr(encode_rtype(mips_pkg::FN_ADD, 6, 2, 4));
        run_program();
        check_value("exc_cause", 32'(mips_pkg::EXC_OVERFLOW), 32'(exc_cause));
        check_value("epc", fault_pc, epc);
        read_register(3, value);
        check_value("r3", 32'd77, value);  // old value kept
        read_register(2, value);
        check_value("r2", 32'd3, value);
        report_test("overflow");
    endtask

    task automatic run_illegal_case();
        program_len = 0;
        append_instr(encode_itype(mips_pkg::OPC_ADDI, 1, 0, 16'd4));
        append_instr({6'h3F, 26'd0});
        append_instr(encode_itype(mips_pkg::OPC_ADDI, 2, 0, 16'd5));
        append_instr(encode_rtype(mips_pkg::FN_ADD, 3, 1, 1));
        run_program();
        check_value("exc_cause", 32'(mips_pkg::EXC_ILLEGAL), 32'(exc_cause));
        check_value("epc", mips_pkg::RESET_PC + 32'd4, epc);
        report_test("illegal");
    endtask

    task automatic run_zero_write_case();
        mips_pkg::word_t value;
        program_len = 0;
        append_instr(encode_itype(mips_pkg::OPC_ADDI, 1, 0, 16'd4));
        append_instr(encode_itype(mips_pkg::OPC_ADDI, 2, 0, 16'd6));
        append_instr(encode_rtype(mips_pkg::FN_ADD, 0, 1, 2));
        append_instr(encode_itype(mips_pkg::OPC_ADDI, 3, 0, 16'd1));
        run_program();
        check_value("exc_cause", 32'(mips_pkg::EXC_ZERO_WRITE), 32'(exc_cause));
        check_value("epc", mips_pkg::RESET_PC + 32'd8, epc);
        read_register(0, value);
        check_value("r0", 32'd0, value);
        report_test("zero_write");
    endtask

    initial
    begin
        SYS_reset    = 1'b1;
        dbg_addr     = '0;
        program_len  = 0;
        test_errors  = 0;
        tests_passed = 0;
        tests_failed = 0;
        run_alu_chain();
        run_branch_mix();
        run_overflow_case();
        run_illegal_case();
        run_zero_write_case();
        check_reset_state();  // halted core with written registers goes back to zero
        $display("tests passed: %0d, tests failed: %0d", tests_passed, tests_failed);
        if (tests_failed == 0)
            $display("STATUS: PASS");
        else
            $display("STATUS: FAIL");
        $finish;
    end

endmodule

/* source/mips_core.sv */
`timescale 1ns/1ps

module mips_core
(
    input  logic                 SYS_clk,
    input  logic                 SYS_reset,
    output mips_pkg::word_t      imem_addr,
    input  mips_pkg::word_t      imem_data,
    input  mips_pkg::reg_addr_t  dbg_addr,
    output mips_pkg::word_t      dbg_data,
    output logic                 halted,
    output mips_pkg::exc_cause_t exc_cause,
    output mips_pkg::word_t      epc
);

    mips_pkg::word_t      fetched_pc;
    logic                 branch_taken;
    mips_pkg::word_t      branch_target;
    mips_pkg::word_t      ex_src_a;
    mips_pkg::word_t      ex_src_b;
    mips_pkg::word_t      ex_imm;
    mips_pkg::reg_addr_t  ex_dest;
    logic                 ex_writes;
    mips_pkg::alu_op_t    ex_alu_op;
    logic                 ex_use_imm;
    mips_pkg::word_t      ex_pc;
    mips_pkg::exc_cause_t ex_cause;
    mips_pkg::reg_addr_t  rs;
    mips_pkg::reg_addr_t  rt;
    logic                 rs_used;
    logic                 rt_used;
    mips_pkg::reg_addr_t  ex_busy_dest;
    logic                 ex_busy_writes;
    mips_pkg::reg_addr_t  wb_dest;
    mips_pkg::word_t      wb_data;
    logic                 wb_writes;
    logic                 wb_we;
    mips_pkg::exc_cause_t wb_cause;
    mips_pkg::word_t      wb_pc;
    logic                 stall;
    logic                 fwd_a;
    logic                 fwd_b;
    logic                 flush;

    fetch_unit u_fetch
    (
        .SYS_clk       (SYS_clk),
        .SYS_reset     (SYS_reset),
        .stall         (stall),
        .flush         (flush),
        .branch_taken  (branch_taken),
        .branch_target (branch_target),
        .pc            (imem_addr),
        .fetched_pc    (fetched_pc)
    );

    decode_stage u_decode
    (
        .SYS_clk       (SYS_clk),
        .SYS_reset     (SYS_reset),
        .stall         (stall),
        .flush         (flush),
        .instr         (imem_data),
        .fetched_pc    (fetched_pc),
        .fwd_a         (fwd_a),
        .fwd_b         (fwd_b),
        .wb_data       (wb_data),
        .wb_we         (wb_we),
        .wb_dest       (wb_dest),
        .dbg_addr      (dbg_addr),
        .ex_src_a      (ex_src_a),
        .ex_src_b      (ex_src_b),
        .ex_imm        (ex_imm),
        .ex_dest       (ex_dest),
        .ex_writes     (ex_writes),
        .ex_alu_op     (ex_alu_op),
        .ex_use_imm    (ex_use_imm),
        .ex_pc         (ex_pc),
        .ex_cause      (ex_cause),
        .rs            (rs),
        .rt            (rt),
        .rs_used       (rs_used),
        .rt_used       (rt_used),
        .branch_taken  (branch_taken),
        .branch_target (branch_target),
        .dbg_data      (dbg_data)
    );

    execute_stage u_execute
    (
        .SYS_clk        (SYS_clk),
        .SYS_reset      (SYS_reset),
        .stall          (stall),
        .flush          (flush),
        .ex_src_a       (ex_src_a),
        .ex_src_b       (ex_src_b),
        .ex_imm         (ex_imm),
        .ex_dest        (ex_dest),
        .ex_writes      (ex_writes),
        .ex_alu_op      (ex_alu_op),
        .ex_use_imm     (ex_use_imm),
        .ex_pc          (ex_pc),
        .ex_cause       (ex_cause),
        .ex_busy_dest   (ex_busy_dest),
        .ex_busy_writes (ex_busy_writes),
        .wb_dest        (wb_dest),
        .wb_data        (wb_data),
        .wb_writes      (wb_writes),
        .wb_we          (wb_we),
        .wb_cause       (wb_cause),
        .wb_pc          (wb_pc)
    );

    hazard_control u_hazard
    (
        .SYS_clk        (SYS_clk),
        .SYS_reset      (SYS_reset),
        .rs             (rs),
        .rt             (rt),
        .rs_used        (rs_used),
        .rt_used        (rt_used),
        .ex_busy_dest   (ex_busy_dest),
        .ex_busy_writes (ex_busy_writes),
        .wb_dest        (wb_dest),
        .wb_writes      (wb_writes),
        .wb_cause       (wb_cause),
        .wb_pc          (wb_pc),
        .stall          (stall),
        .fwd_a          (fwd_a),
        .fwd_b          (fwd_b),
        .flush          (flush),
        .halted         (halted),
        .exc_cause      (exc_cause),
        .epc            (epc)
    );

endmodule

/* source/hazard_control.sv */
`timescale 1ns/1ps

module hazard_control
(
    input  logic                 SYS_clk,
    input  logic                 SYS_reset,
    input  mips_pkg::reg_addr_t  rs,
    input  mips_pkg::reg_addr_t  rt,
    input  logic                 rs_used,
    input  logic                 rt_used,
    input  mips_pkg::reg_addr_t  ex_busy_dest,
    input  logic                 ex_busy_writes,
    input  mips_pkg::reg_addr_t  wb_dest,
    input  logic                 wb_writes,
    input  mips_pkg::exc_cause_t wb_cause,
    input  mips_pkg::word_t      wb_pc,
    output logic                 stall,
    output logic                 fwd_a,
    output logic                 fwd_b,
    output logic                 flush,
    output logic                 halted,
    output mips_pkg::exc_cause_t exc_cause,
    output mips_pkg::word_t      epc
);

    mips_pkg::core_state_t state_q;
    logic                  ex_hit_a;
    logic                  ex_hit_b;
    logic                  wb_excepts;

    // execute result not ready yet, wait one cycle
    assign ex_hit_a = rs_used && rs != '0 && ex_busy_writes && rs == ex_busy_dest;
    assign ex_hit_b = rt_used && rt != '0 && ex_busy_writes && rt == ex_busy_dest;
    assign stall    = ex_hit_a || ex_hit_b;

    assign fwd_a = rs_used && rs != '0 && wb_writes && rs == wb_dest;
    assign fwd_b = rt_used && rt != '0 && wb_writes && rt == wb_dest;

    assign wb_excepts = (wb_cause != mips_pkg::EXC_NONE);
    assign halted     = (state_q == mips_pkg::CORE_HALTED);
    assign flush      = halted || wb_excepts;

    always_ff @(posedge SYS_clk or posedge SYS_reset)
    begin
        if (SYS_reset)
        begin
            state_q   <= mips_pkg::CORE_RUN;
            exc_cause <= mips_pkg::EXC_NONE;
            epc       <= '0;
        end
        else
        begin
            case (state_q)
                mips_pkg::CORE_RUN:
                begin
                    if (wb_excepts)
                    begin
                        state_q   <= mips_pkg::CORE_HALTED;
                        exc_cause <= wb_cause;
                        epc       <= wb_pc;  // address of the faulting op
                    end
                end
                default: state_q <= mips_pkg::CORE_HALTED;  // only reset leaves halt
            endcase
        end
    end

endmodule

/* source/execute_stage.sv */
`timescale 1ns/1ps

module execute_stage
(
    input  logic                 SYS_clk,
    input  logic                 SYS_reset,
    input  logic                 stall,
    input  logic                 flush,
    input  mips_pkg::word_t      ex_src_a,
    input  mips_pkg::word_t      ex_src_b,
    input  mips_pkg::word_t      ex_imm,
    input  mips_pkg::reg_addr_t  ex_dest,
    input  logic                 ex_writes,
    input  mips_pkg::alu_op_t    ex_alu_op,
    input  logic                 ex_use_imm,
    input  mips_pkg::word_t      ex_pc,
    input  mips_pkg::exc_cause_t ex_cause,
    output mips_pkg::reg_addr_t  ex_busy_dest,
    output logic                 ex_busy_writes,
    output mips_pkg::reg_addr_t  wb_dest,
    output mips_pkg::word_t      wb_data,
    output logic                 wb_writes,
    output logic                 wb_we,
    output mips_pkg::exc_cause_t wb_cause,
    output mips_pkg::word_t      wb_pc
);

    logic                 writes_q;
    mips_pkg::exc_cause_t cause_q;
    mips_pkg::word_t      a_q;
    mips_pkg::word_t      b_q;
    mips_pkg::word_t      imm_q;
    mips_pkg::reg_addr_t  dest_q;
    mips_pkg::alu_op_t    alu_op_q;
    logic                 use_imm_q;
    mips_pkg::word_t      pc_q;
    mips_pkg::word_t      opb;
    mips_pkg::word_t      result;
    logic                 overflow;
    mips_pkg::exc_cause_t cause_out;

    // control part of the decode-to-execute register
    always_ff @(posedge SYS_clk or posedge SYS_reset)
    begin
        if (SYS_reset)
        begin
            writes_q <= 1'b0;
            cause_q  <= mips_pkg::EXC_NONE;
        end
        else if (stall || flush)
        begin
            writes_q <= 1'b0;  // bubble
            cause_q  <= mips_pkg::EXC_NONE;
        end
        else
        begin
            writes_q <= ex_writes;
            cause_q  <= ex_cause;
        end
    end

    always_ff @(posedge SYS_clk)
    begin
        a_q       <= ex_src_a;
        b_q       <= ex_src_b;
        imm_q     <= ex_imm;
        dest_q    <= ex_dest;
        alu_op_q  <= ex_alu_op;
        use_imm_q <= ex_use_imm;
        pc_q      <= ex_pc;
    end

    assign opb = use_imm_q ? imm_q : b_q;

    always_comb
    begin
        overflow = 1'b0;
        case (alu_op_q)
            mips_pkg::ALU_ADD:
            begin
                result   = a_q + opb;
                overflow = (a_q[31] == opb[31]) && (result[31] != a_q[31]);
            end
            mips_pkg::ALU_SUB:
            begin
                result   = a_q - opb;
                overflow = (a_q[31] != opb[31]) && (result[31] != a_q[31]);
            end
            mips_pkg::ALU_AND: result = a_q & opb;
            mips_pkg::ALU_OR:  result = a_q | opb;
            mips_pkg::ALU_SLT: result = {31'd0, $signed(a_q) < $signed(opb)};
            default:           result = '0;
        endcase
    end

    // decode cause wins, overflow only counts for a writing op
    always_comb
    begin
        if (cause_q != mips_pkg::EXC_NONE)
            cause_out = cause_q;
        else if (writes_q && overflow)
            cause_out = mips_pkg::EXC_OVERFLOW;
        else
            cause_out = mips_pkg::EXC_NONE;
    end

    assign ex_busy_dest   = dest_q;
    assign ex_busy_writes = writes_q;

    always_ff @(posedge SYS_clk or posedge SYS_reset)
    begin
        if (SYS_reset)
        begin
            wb_writes <= 1'b0;
            wb_cause  <= mips_pkg::EXC_NONE;
        end
        else if (flush)
        begin
            wb_writes <= 1'b0;
            wb_cause  <= mips_pkg::EXC_NONE;
        end
        else
        begin
            wb_writes <= writes_q;
            wb_cause  <= cause_out;
        end
    end

    always_ff @(posedge SYS_clk)
    begin
        wb_data <= result;
        wb_dest <= dest_q;
        wb_pc   <= pc_q;
    end

    assign wb_we = wb_writes && (wb_cause == mips_pkg::EXC_NONE);  // excepting op never commits

endmodule

/* source/decode_stage.sv */
`timescale 1ns/1ps

module decode_stage
(
    input  logic                 SYS_clk,
    input  logic                 SYS_reset,
    input  logic                 stall,
    input  logic                 flush,
    input  mips_pkg::word_t      instr,
    input  mips_pkg::word_t      fetched_pc,
    input  logic                 fwd_a,
    input  logic                 fwd_b,
    input  mips_pkg::word_t      wb_data,
    input  logic                 wb_we,
    input  mips_pkg::reg_addr_t  wb_dest,
    input  mips_pkg::reg_addr_t  dbg_addr,
    output mips_pkg::word_t      ex_src_a,
    output mips_pkg::word_t      ex_src_b,
    output mips_pkg::word_t      ex_imm,
    output mips_pkg::reg_addr_t  ex_dest,
    output logic                 ex_writes,
    output mips_pkg::alu_op_t    ex_alu_op,
    output logic                 ex_use_imm,
    output mips_pkg::word_t      ex_pc,
    output mips_pkg::exc_cause_t ex_cause,
    output mips_pkg::reg_addr_t  rs,
    output mips_pkg::reg_addr_t  rt,
    output logic                 rs_used,
    output logic                 rt_used,
    output logic                 branch_taken,
    output mips_pkg::word_t      branch_target,
    output mips_pkg::word_t      dbg_data
);

    logic            valid_q;   // low means bubble
    mips_pkg::word_t instr_q;
    mips_pkg::word_t pc_q;
    mips_pkg::word_t file_a;
    mips_pkg::word_t file_b;
    logic            is_beq;
    logic            is_bne;
    logic            illegal;
    logic            src_equal;

    always_ff @(posedge SYS_clk or posedge SYS_reset)
    begin
        if (SYS_reset)
            valid_q <= 1'b0;
        else if (flush)
            valid_q <= 1'b0;
        else if (!stall)
            valid_q <= !branch_taken;  // kill the wrong-path fetch
    end

    always_ff @(posedge SYS_clk)
    begin
        if (!stall)
        begin
            instr_q <= instr;
            pc_q    <= fetched_pc;
        end
    end

    assign rs     = instr_q[25:21];
    assign rt     = instr_q[20:16];
    assign ex_imm = {{16{instr_q[15]}}, instr_q[15:0]};
    assign ex_pc  = pc_q;

    always_comb
    begin
        ex_alu_op  = mips_pkg::ALU_ADD;
        ex_use_imm = 1'b0;
        ex_writes  = 1'b0;
        ex_dest    = instr_q[15:11];  // rd for R-type
        rs_used    = 1'b0;
        rt_used    = 1'b0;
        is_beq     = 1'b0;
        is_bne     = 1'b0;
        illegal    = 1'b0;
        if (valid_q)
        begin
            case (instr_q[31:26])
                mips_pkg::OPC_RTYPE:
                begin
                    ex_writes = 1'b1;
                    rs_used   = 1'b1;
                    rt_used   = 1'b1;
                    case (instr_q[5:0])
                        mips_pkg::FN_ADD: ex_alu_op = mips_pkg::ALU_ADD;
                        mips_pkg::FN_SUB: ex_alu_op = mips_pkg::ALU_SUB;
                        mips_pkg::FN_AND: ex_alu_op = mips_pkg::ALU_AND;
                        mips_pkg::FN_OR:  ex_alu_op = mips_pkg::ALU_OR;
                        mips_pkg::FN_SLT: ex_alu_op = mips_pkg::ALU_SLT;
                        default:
                        begin
                            illegal   = 1'b1;
                            ex_writes = 1'b0;
                            rs_used   = 1'b0;
                            rt_used   = 1'b0;
                        end
                    endcase
                end
                mips_pkg::OPC_ADDI:
                begin
                    ex_writes  = 1'b1;
                    ex_use_imm = 1'b1;
                    ex_dest    = instr_q[20:16];  // rt for I-type
                    rs_used    = 1'b1;
                end
                mips_pkg::OPC_BEQ, mips_pkg::OPC_BNE:
                begin
                    is_beq  = (instr_q[31:26] == mips_pkg::OPC_BEQ);
                    is_bne  = (instr_q[31:26] == mips_pkg::OPC_BNE);
                    rs_used = 1'b1;
                    rt_used = 1'b1;
                end
                default: illegal = 1'b1;
            endcase
        end
    end

    // illegal outranks zero write, both found here
    always_comb
    begin
        if (illegal)
            ex_cause = mips_pkg::EXC_ILLEGAL;
        else if (ex_writes && ex_dest == '0)
            ex_cause = mips_pkg::EXC_ZERO_WRITE;
        else
            ex_cause = mips_pkg::EXC_NONE;
    end

    register_file u_regs
    (
        .SYS_clk   (SYS_clk),
        .SYS_reset (SYS_reset),
        .rd_addr_a (rs),
        .rd_addr_b (rt),
        .dbg_addr  (dbg_addr),
        .we        (wb_we),
        .wr_addr   (wb_dest),
        .wr_data   (wb_data),
        .rd_data_a (file_a),
        .rd_data_b (file_b),
        .dbg_data  (dbg_data)
    );

    assign ex_src_a = fwd_a ? wb_data : file_a;  // writeback bypass
    assign ex_src_b = fwd_b ? wb_data : file_b;

    assign src_equal     = (ex_src_a == ex_src_b);
    assign branch_taken  = !stall && ((is_beq && src_equal) || (is_bne && !src_equal));
    assign branch_target = pc_q + 32'd4 + {ex_imm[29:0], 2'b00};

endmodule

/* source/register_file.sv */
`timescale 1ns/1ps

module register_file
(
    input  logic               SYS_clk,
    input  logic               SYS_reset,
    input  mips_pkg::reg_addr_t rd_addr_a,
    input  mips_pkg::reg_addr_t rd_addr_b,
    input  mips_pkg::reg_addr_t dbg_addr,
    input  logic               we,
    input  mips_pkg::reg_addr_t wr_addr,
    input  mips_pkg::word_t     wr_data,
    output mips_pkg::word_t     rd_data_a,
    output mips_pkg::word_t     rd_data_b,
    output mips_pkg::word_t     dbg_data
);

    mips_pkg::word_t regs [mips_pkg::NUM_REGS];

    always_ff @(posedge SYS_clk or posedge SYS_reset)
    begin
        if (SYS_reset)
        begin
            for (int i = 0; i < mips_pkg::NUM_REGS; i++)
                regs[i] <= '0;
        end
        else if (we && wr_addr != '0)
        begin
            regs[wr_addr] <= wr_data;  // r0 never written
        end
    end

    // r0 stays zero so plain indexing is enough
    assign rd_data_a = regs[rd_addr_a];
    assign rd_data_b = regs[rd_addr_b];
    assign dbg_data  = regs[dbg_addr];

endmodule

/* source/fetch_unit.sv */
`timescale 1ns/1ps

module fetch_unit
(
    input  logic           SYS_clk,
    input  logic           SYS_reset,
    input  logic           stall,
    input  logic           flush,
    input  logic           branch_taken,
    input  mips_pkg::word_t branch_target,
    output mips_pkg::word_t pc,
    output mips_pkg::word_t fetched_pc
);

    mips_pkg::word_t pc_q;
    mips_pkg::word_t pc_next;

    always_comb
    begin
        if (flush || stall)
            pc_next = pc_q;           // halt or dependency hold
        else if (branch_taken)
            pc_next = branch_target;  // redirect from decode
        else
            pc_next = pc_q + 32'd4;
    end

    always_ff @(posedge SYS_clk or posedge SYS_reset)
    begin
        if (SYS_reset)
            pc_q <= mips_pkg::RESET_PC;
        else
            pc_q <= pc_next;
    end

    assign pc         = pc_q;  // to instruction memory
    assign fetched_pc = pc_q;  // address of the word now on imem_data

endmodule

/* source/mips_pkg.sv */
package mips_pkg;

    typedef logic [31:0] word_t;      // data and address word
    typedef logic [4:0]  reg_addr_t;  // register number
    typedef logic [2:0]  alu_op_t;    // alu operation select
    typedef logic [2:0]  exc_cause_t; // exception cause code

    typedef enum logic
    {
        CORE_RUN,
        CORE_HALTED
    } core_state_t;

    // exception causes, zero means the instruction is clean
    localparam exc_cause_t EXC_NONE       = 3'd0;
    localparam exc_cause_t EXC_ILLEGAL    = 3'd1;
    localparam exc_cause_t EXC_OVERFLOW   = 3'd2;
    localparam exc_cause_t EXC_ZERO_WRITE = 3'd7;

    localparam logic [5:0] OPC_RTYPE = 6'd0;
    localparam logic [5:0] OPC_BEQ   = 6'd4;
    localparam logic [5:0] OPC_BNE   = 6'd5;
    localparam logic [5:0] OPC_ADDI  = 6'd8;

    localparam logic [5:0] FN_ADD = 6'h20;
    localparam logic [5:0] FN_SUB = 6'h22;
    localparam logic [5:0] FN_AND = 6'h24;
    localparam logic [5:0] FN_OR  = 6'h25;
    localparam logic [5:0] FN_SLT = 6'h2A;

    localparam alu_op_t ALU_ADD = 3'd0;
    localparam alu_op_t ALU_SUB = 3'd1;
    localparam alu_op_t ALU_AND = 3'd2;
    localparam alu_op_t ALU_OR  = 3'd3;
    localparam alu_op_t ALU_SLT = 3'd4;

    localparam word_t RESET_PC = 32'h0040_0000; // first fetch address
    localparam int    NUM_REGS = 32;

endpackage
